/* source/agg_params.svh */
/*
 * aggregation engine sizing: lanes, word and edge widths,
 * buffer geometry and read latency
 */
`ifndef AGG_PARAMS_SVH
`define AGG_PARAMS_SVH

// buffer word layout
`define AGG_LANES 16
`define AGG_LANE_WIDTH 32
`define AGG_BEAT_WIDTH 512

// one feature buffer and one output buffer, 2048 words each
`define AGG_BUF_ADDR_WIDTH 11
`define AGG_BUF_READ_LATENCY 3

// edge list stream
`define AGG_EDGE_WIDTH 64
`define AGG_EDGES_PER_BEAT 8

// control side
`define AGG_INST_WIDTH 128
`define AGG_DRAM_ADDR_WIDTH 64
`define AGG_XFER_SIZE_WIDTH 32

`endif

/* source/agg_pkg.sv */
/*
 * aggregation engine types: controller states and shared vectors
 */
`default_nettype none

`include "agg_params.svh"

package agg_pkg;

  //////////////////////////////////////////////////////////////////////
  // controller FSM
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    AGG_IDLE,
    AGG_LOAD,
    AGG_RECEIVE,
    AGG_ISSUE,
    AGG_DRAIN
  } agg_state_e;

  //////////////////////////////////////////////////////////////////////
  // datapath vectors
  //////////////////////////////////////////////////////////////////////
  // word address into either buffer
  typedef logic [`AGG_BUF_ADDR_WIDTH-1:0] agg_buf_addr_t;

  // one lane, also the edge weight
  typedef logic [`AGG_LANE_WIDTH-1:0] agg_lane_t;

  // full buffer word or stream beat
  typedef logic [`AGG_BEAT_WIDTH-1:0] agg_beat_t;

endpackage

`default_nettype wire

/* source/agg_controller.sv */
/*
 * aggregation controller: decodes the instruction, requests the edge list,
 * takes stream beats, unpacks edges and issues one buffer word per cycle
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module agg_controller import agg_pkg::*; (
  input  logic                             kernel_rst,
  input  logic                             kernel_clk,
  input  logic                             ap_start,
  input  logic [`AGG_DRAM_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  logic [`AGG_INST_WIDTH-1:0]       ctrl_instruction,
  input  logic                             data_tvalid,
  input  agg_beat_t                        data_tdata,
  input  logic                             edge_done,
  output logic [`AGG_DRAM_ADDR_WIDTH-1:0]  dram_xfer_start_addr,
  output logic [`AGG_XFER_SIZE_WIDTH-1:0]  dram_xfer_size_in_bytes,
  output logic                             read_start,
  output logic                             data_tready,
  output logic                             ap_done,
  output logic                             issue_valid,
  output logic                             issue_first,
  output logic                             issue_finish,
  output agg_buf_addr_t                    issue_in_addr,
  output agg_buf_addr_t                    issue_out_addr,
  output agg_lane_t                        issue_weight
);

  localparam int FIELD_W    = 16;
  localparam int EDGE_IDX_W = $clog2(`AGG_EDGES_PER_BEAT);
  localparam int BEAT_IDX_W = FIELD_W - EDGE_IDX_W;

  agg_state_e state_q;

  // instruction fields
  logic [`AGG_DRAM_ADDR_WIDTH-1:0] dram_offset;
  logic [FIELD_W-1:0]              input_start_address;
  logic [FIELD_W-1:0]              address_per_feature;
  logic [FIELD_W-1:0]              output_start_address;
  logic [FIELD_W-1:0]              adj_dram_start_address;
  logic [FIELD_W-1:0]              edge_number;

  // current beat and walk counters
  agg_beat_t                       beat_q;
  logic [BEAT_IDX_W-1:0]           beat_idx;
  logic [BEAT_IDX_W-1:0]           beat_num;
  logic [EDGE_IDX_W-1:0]           edge_idx;
  logic [FIELD_W-1:0]              word_idx;

  logic [`AGG_EDGE_WIDTH-1:0]      cur_edge;
  logic                            beat_accept;
  logic                            last_word;
  logic                            last_edge;
  logic                            last_beat;

  //////////////////////////////////////////////////////////////////////
  // DRAM request and counters
  //////////////////////////////////////////////////////////////////////
  assign dram_xfer_start_addr    = dram_offset + `AGG_DRAM_ADDR_WIDTH'(adj_dram_start_address);
  assign dram_xfer_size_in_bytes = `AGG_XFER_SIZE_WIDTH'(edge_number) << 3;

  // eight edges per beat
  assign beat_num    = edge_number[FIELD_W-1:EDGE_IDX_W];
  assign beat_accept = (state_q == AGG_RECEIVE) && data_tvalid && data_tready;
  assign last_word   = (word_idx == address_per_feature - 16'd1);
  assign last_edge   = (edge_idx == EDGE_IDX_W'(`AGG_EDGES_PER_BEAT - 1));
  assign last_beat   = (beat_idx == beat_num - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // edge unpacking and word issue
  //////////////////////////////////////////////////////////////////////
  assign cur_edge = beat_q[edge_idx*`AGG_EDGE_WIDTH +: `AGG_EDGE_WIDTH];

  assign issue_valid  = (state_q == AGG_ISSUE);
  assign issue_finish = issue_valid && last_word;
  assign issue_first  = cur_edge[15];
  assign issue_weight = cur_edge[63:32];

  // start + per_feature * node + word, wrapping at the buffer size
  assign issue_in_addr  = agg_buf_addr_t'(input_start_address)
                        + agg_buf_addr_t'(address_per_feature) * agg_buf_addr_t'(cur_edge[14:0])
                        + agg_buf_addr_t'(word_idx);
  assign issue_out_addr = agg_buf_addr_t'(output_start_address)
                        + agg_buf_addr_t'(address_per_feature) * agg_buf_addr_t'(cur_edge[30:16])
                        + agg_buf_addr_t'(word_idx);

  always_ff @(posedge kernel_rst) begin
    if (beat_accept) begin
      beat_q <= data_tdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      state_q                <= AGG_IDLE;
      dram_offset            <= '0;
      input_start_address    <= '0;
      address_per_feature    <= '0;
      output_start_address   <= '0;
      adj_dram_start_address <= '0;
      edge_number            <= '0;
      beat_idx               <= '0;
      edge_idx               <= '0;
      word_idx               <= '0;
      read_start             <= 1'b0;
      data_tready            <= 1'b0;
      ap_done                <= 1'b0;
    end else begin
      // strobes
      read_start <= 1'b0;
      ap_done    <= 1'b0;
      case (state_q)
        AGG_IDLE: begin
          if (ap_start) begin
            dram_offset            <= ctrl_addr_offset;
            input_start_address    <= ctrl_instruction[47:32];
            address_per_feature    <= ctrl_instruction[63:48];
            output_start_address   <= ctrl_instruction[79:64];
            adj_dram_start_address <= ctrl_instruction[111:96];
            edge_number            <= ctrl_instruction[127:112];
            state_q                <= AGG_LOAD;
          end
        end
        AGG_LOAD: begin
          read_start  <= 1'b1;
          data_tready <= 1'b1;
          beat_idx    <= '0;
          state_q     <= AGG_RECEIVE;
        end
        AGG_RECEIVE: begin
          if (beat_accept) begin
            data_tready <= 1'b0;
            edge_idx    <= '0;
            word_idx    <= '0;
            state_q     <= AGG_ISSUE;
          end
        end
        AGG_ISSUE: begin
          if (last_word) begin
            state_q <= AGG_DRAIN;
          end else begin
            word_idx <= word_idx + 16'd1;
          end
        end
        AGG_DRAIN: begin
          // whole edge written back before the next one reads
          if (edge_done) begin
            word_idx <= '0;
            if (!last_edge) begin
              edge_idx <= edge_idx + 1'b1;
              state_q  <= AGG_ISSUE;
            end else if (last_beat) begin
              ap_done <= 1'b1;
              state_q <= AGG_IDLE;
            end else begin
              beat_idx    <= beat_idx + 1'b1;
              data_tready <= 1'b1;
              state_q     <= AGG_RECEIVE;
            end
          end
        end
        default: begin
          state_q <= AGG_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/agg_feature_fetch.sv */
/*
 * feature fetch: registers the feature and output buffer reads and
 * delays the edge context to meet the returning data
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module agg_feature_fetch import agg_pkg::*; (
  input  logic          kernel_rst,
  input  logic          kernel_clk,
  input  logic          issue_valid,
  input  logic          issue_first,
  input  logic          issue_finish,
  input  agg_buf_addr_t issue_in_addr,
  input  agg_buf_addr_t issue_out_addr,
  input  agg_lane_t     issue_weight,
  output logic          feat_rd_en,
  output agg_buf_addr_t feat_rd_addr,
  output logic          out_rd_en,
  output agg_buf_addr_t out_rd_addr,
  output logic          fetched_valid,
  output logic          fetched_first,
  output logic          fetched_finish,
  output agg_buf_addr_t fetched_out_addr,
  output agg_lane_t     fetched_weight
);

  localparam int LAT = `AGG_BUF_READ_LATENCY;

  // context held next to the read request
  logic          req_first;
  logic          req_finish;
  agg_lane_t     req_weight;

  // delay line, one stage per cycle of buffer latency
  logic [LAT-1:0] dl_valid;
  logic [LAT-1:0] dl_first;
  logic [LAT-1:0] dl_finish;
  agg_buf_addr_t  dl_out_addr [LAT];
  agg_lane_t      dl_weight [LAT];

  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      feat_rd_en <= 1'b0;
      out_rd_en  <= 1'b0;
      req_first  <= 1'b0;
      req_finish <= 1'b0;
      dl_valid   <= '0;
      dl_first   <= '0;
      dl_finish  <= '0;
    end else begin
      feat_rd_en   <= issue_valid;
      out_rd_en    <= issue_valid;
      req_first    <= issue_valid && issue_first;
      req_finish   <= issue_valid && issue_finish;
      dl_valid[0]  <= feat_rd_en;
      dl_first[0]  <= req_first;
      dl_finish[0] <= req_finish;
      for (int i = 1; i < LAT; i++) begin
        dl_valid[i]  <= dl_valid[i-1];
        dl_first[i]  <= dl_first[i-1];
        dl_finish[i] <= dl_finish[i-1];
      end
    end
  end

  // addresses and weight
  always_ff @(posedge kernel_rst) begin
    if (issue_valid) begin
      feat_rd_addr <= issue_in_addr;
      out_rd_addr  <= issue_out_addr;
      req_weight   <= issue_weight;
    end
    // the output read address doubles as the write-back address
    dl_out_addr[0] <= out_rd_addr;
    dl_weight[0]   <= req_weight;
    for (int i = 1; i < LAT; i++) begin
      dl_out_addr[i] <= dl_out_addr[i-1];
      dl_weight[i]   <= dl_weight[i-1];
    end
  end

  assign fetched_valid    = dl_valid[LAT-1];
  assign fetched_first    = dl_first[LAT-1];
  assign fetched_finish   = dl_finish[LAT-1];
  assign fetched_out_addr = dl_out_addr[LAT-1];
  assign fetched_weight   = dl_weight[LAT-1];

endmodule

`default_nettype wire

/* source/agg_mac_array.sv */
/*
 * sixteen-lane multiply-accumulate: weight x feature plus partial sum,
 * written back to the output buffer
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module agg_mac_array import agg_pkg::*; (
  input  logic          kernel_rst,
  input  logic          kernel_clk,
  input  logic          fetched_valid,
  input  logic          fetched_first,
  input  logic          fetched_finish,
  input  agg_buf_addr_t fetched_out_addr,
  input  agg_lane_t     fetched_weight,
  input  agg_beat_t     feat_rd_data,
  input  agg_beat_t     out_rd_data,
  output logic          out_wr_en,
  output agg_buf_addr_t out_wr_addr,
  output agg_beat_t     out_wr_data,
  output logic          edge_done
);

  localparam int LANES = `AGG_LANES;
  localparam int LW    = `AGG_LANE_WIDTH;

  // multiply stage
  logic          mul_valid;
  logic          mul_finish;
  agg_buf_addr_t mul_addr;
  agg_beat_t     mul_prod;
  agg_beat_t     mul_old;

  //////////////////////////////////////////////////////////////////////
  // stage control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      mul_valid  <= 1'b0;
      mul_finish <= 1'b0;
      out_wr_en  <= 1'b0;
      edge_done  <= 1'b0;
    end else begin
      mul_valid  <= fetched_valid;
      mul_finish <= fetched_valid && fetched_finish;
      out_wr_en  <= mul_valid;
      // last word of the edge lands this cycle
      edge_done  <= mul_valid && mul_finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane datapath
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst) begin
    if (fetched_valid) begin
      mul_addr <= fetched_out_addr;
      // first edge of a destination starts from zero
      mul_old  <= fetched_first ? '0 : out_rd_data;
      for (int i = 0; i < LANES; i++) begin
        // low 32 bits of the product only
        mul_prod[i*LW +: LW] <= fetched_weight * feat_rd_data[i*LW +: LW];
      end
    end
    if (mul_valid) begin
      out_wr_addr <= mul_addr;
      for (int i = 0; i < LANES; i++) begin
        out_wr_data[i*LW +: LW] <= mul_prod[i*LW +: LW] + mul_old[i*LW +: LW];
      end
    end
  end

endmodule

`default_nettype wire

/* source/agg_top.sv */
/*
 * aggregation engine top: controller, feature fetch and MAC array
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module agg_top import agg_pkg::*; (
  input  logic                             kernel_rst,
  input  logic                             kernel_clk,
  // control
  input  logic                             ap_start,
  output logic                             ap_done,
  input  logic [`AGG_DRAM_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  logic [`AGG_INST_WIDTH-1:0]       ctrl_instruction,
  // edge list request and stream
  output logic [`AGG_DRAM_ADDR_WIDTH-1:0]  dram_xfer_start_addr,
  output logic [`AGG_XFER_SIZE_WIDTH-1:0]  dram_xfer_size_in_bytes,
  output logic                             read_start,
  input  logic                             data_tvalid,
  output logic                             data_tready,
  input  agg_beat_t                        data_tdata,
  // feature buffer
  output logic                             feat_rd_en,
  output agg_buf_addr_t                    feat_rd_addr,
  input  agg_beat_t                        feat_rd_data,
  // output buffer
  output logic                             out_rd_en,
  output agg_buf_addr_t                    out_rd_addr,
  input  agg_beat_t                        out_rd_data,
  output logic                             out_wr_en,
  output agg_buf_addr_t                    out_wr_addr,
  output agg_beat_t                        out_wr_data
);

  // controller to fetch
  logic          issue_valid;
  logic          issue_first;
  logic          issue_finish;
  agg_buf_addr_t issue_in_addr;
  agg_buf_addr_t issue_out_addr;
  agg_lane_t     issue_weight;

  // fetch to MAC
  logic          fetched_valid;
  logic          fetched_first;
  logic          fetched_finish;
  agg_buf_addr_t fetched_out_addr;
  agg_lane_t     fetched_weight;

  logic          edge_done;

  agg_controller i_controller (
    .kernel_rst, .kernel_clk, .ap_start, .ctrl_addr_offset, .ctrl_instruction,
    .data_tvalid, .data_tdata, .edge_done, .dram_xfer_start_addr,
    .dram_xfer_size_in_bytes, .read_start, .data_tready, .ap_done,
    .issue_valid, .issue_first, .issue_finish, .issue_in_addr, .issue_out_addr,
    .issue_weight
  );

  agg_feature_fetch i_feature_fetch (
    .kernel_rst, .kernel_clk, .issue_valid, .issue_first, .issue_finish,
    .issue_in_addr, .issue_out_addr, .issue_weight, .feat_rd_en, .feat_rd_addr,
    .out_rd_en, .out_rd_addr, .fetched_valid, .fetched_first, .fetched_finish,
    .fetched_out_addr, .fetched_weight
  );

  agg_mac_array i_mac_array (
    .kernel_rst, .kernel_clk, .fetched_valid, .fetched_first, .fetched_finish,
    .fetched_out_addr, .fetched_weight, .feat_rd_data, .out_rd_data,
    .out_wr_en, .out_wr_addr, .out_wr_data, .edge_done
  );

endmodule

`default_nettype wire

/* verification/tb_agg_buffers.sv */
/*
 * feature and output buffer models for the aggregation engine testbench,
 * 2048 words each with a fixed read latency and a fill port
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module tb_agg_buffers import agg_pkg::*; (
  input  logic          kernel_rst,
  // preload from the testbench
  input  logic          fill_en,
  input  agg_buf_addr_t fill_addr,
  input  agg_beat_t     fill_feat,
  input  agg_beat_t     fill_out,
  // engine side
  input  logic          feat_rd_en,
  input  agg_buf_addr_t feat_rd_addr,
  output agg_beat_t     feat_rd_data,
  input  logic          out_rd_en,
  input  agg_buf_addr_t out_rd_addr,
  output agg_beat_t     out_rd_data,
  input  logic          out_wr_en,
  input  agg_buf_addr_t out_wr_addr,
  input  agg_beat_t     out_wr_data
);

  localparam int LAT   = `AGG_BUF_READ_LATENCY;
  localparam int DEPTH = 1 << `AGG_BUF_ADDR_WIDTH;

  agg_beat_t feat_mem [DEPTH];
  agg_beat_t out_mem [DEPTH];
  agg_beat_t feat_pipe [LAT];
  agg_beat_t out_pipe [LAT];

  always @(posedge kernel_rst) begin
    if (fill_en) begin
      feat_mem[fill_addr] <= fill_feat;
      out_mem[fill_addr]  <= fill_out;
    end else if (out_wr_en) begin
      out_mem[out_wr_addr] <= out_wr_data;
    end
    // first stage reads the array, the rest only delay
    if (feat_rd_en) begin
      feat_pipe[0] <= feat_mem[feat_rd_addr];
    end
    if (out_rd_en) begin
      out_pipe[0] <= out_mem[out_rd_addr];
    end
    for (int i = 1; i < LAT; i++) begin
      feat_pipe[i] <= feat_pipe[i-1];
      out_pipe[i]  <= out_pipe[i-1];
    end
  end

  assign feat_rd_data = feat_pipe[LAT-1];
  assign out_rd_data  = out_pipe[LAT-1];

endmodule

`default_nettype wire

/* verification/tb_agg_top.sv */
/*
 * random instructions and edge beats drive the aggregation engine,
 * and a model of the output buffer checks every write-back
 */
`timescale 1ns/10ps
`default_nettype none

`include "agg_params.svh"

module tb_agg_top import agg_pkg::*;;

  localparam int DEPTH = 1 << `AGG_BUF_ADDR_WIDTH;
  localparam int LW    = `AGG_LANE_WIDTH;

  // kernel_rst clocks the design and kernel_clk is its active high reset
  logic                            kernel_rst;
  logic                            kernel_clk;
  logic                            ap_start;
  logic                            ap_done;
  logic [`AGG_DRAM_ADDR_WIDTH-1:0] ctrl_addr_offset;
  logic [`AGG_INST_WIDTH-1:0]      ctrl_instruction;
  logic [`AGG_DRAM_ADDR_WIDTH-1:0] dram_xfer_start_addr;
  logic [`AGG_XFER_SIZE_WIDTH-1:0] dram_xfer_size_in_bytes;
  logic                            read_start;
  logic                            data_tvalid;
  logic                            data_tready;
  agg_beat_t                       data_tdata;
  logic                            feat_rd_en;
  agg_buf_addr_t                   feat_rd_addr;
  agg_beat_t                       feat_rd_data;
  logic                            out_rd_en;
  agg_buf_addr_t                   out_rd_addr;
  agg_beat_t                       out_rd_data;
  logic                            out_wr_en;
  agg_buf_addr_t                   out_wr_addr;
  agg_beat_t                       out_wr_data;
  logic                            fill_en;
  agg_buf_addr_t                   fill_addr;
  agg_beat_t                       fill_feat;
  agg_beat_t                       fill_out;

  integer        seed = 32'h0fd0_4b10;
  agg_beat_t     feat_model [DEPTH];
  agg_beat_t     out_model [DEPTH];
  agg_beat_t     beat_q [$];
  agg_buf_addr_t exp_addr_q [$];
  agg_beat_t     exp_data_q [$];
  int            write_count = 0;
  int            start_count = 0;
  int            beat_count = 0;
  int            done_count = 0;
  int            feat_read_count = 0;
  int            out_read_count = 0;

  agg_top i_dut (
    .kernel_rst, .kernel_clk, .ap_start, .ap_done, .ctrl_addr_offset, .ctrl_instruction,
    .dram_xfer_start_addr, .dram_xfer_size_in_bytes, .read_start, .data_tvalid,
    .data_tready, .data_tdata, .feat_rd_en, .feat_rd_addr, .feat_rd_data, .out_rd_en,
    .out_rd_addr, .out_rd_data, .out_wr_en, .out_wr_addr, .out_wr_data
  );

  tb_agg_buffers i_buffers (
    .kernel_rst, .fill_en, .fill_addr, .fill_feat, .fill_out, .feat_rd_en, .feat_rd_addr,
    .feat_rd_data, .out_rd_en, .out_rd_addr, .out_rd_data, .out_wr_en, .out_wr_addr,
    .out_wr_data
  );

  initial begin
    kernel_rst = 1'b0;
    forever #50 kernel_rst = ~kernel_rst;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic agg_beat_t random_word();
    agg_beat_t w;
    for (int i = 0; i < `AGG_BEAT_WIDTH / 32; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // monitor for strobes, reads, accepted beats and write-back order
  //////////////////////////////////////////////////////////////////////
  always @(negedge kernel_rst) begin
    if (!kernel_clk) begin
      if (read_start) begin
        start_count++;
      end
      if (ap_done) begin
        done_count++;
      end
      if (feat_rd_en) begin
        feat_read_count++;
      end
      if (out_rd_en) begin
        out_read_count++;
      end
      // tvalid is held through the next rising edge
      if (data_tvalid && data_tready) begin
        beat_count++;
      end
      if (out_wr_en) begin
        if (write_count >= exp_addr_q.size()) begin
          stop_run("write-back seen when the model predicts none");
        end else begin
          check_value("out_wr_addr", exp_addr_q[write_count], out_wr_addr);
          check_value("out_wr_data", exp_data_q[write_count], out_wr_data);
          write_count++;
        end
      end
    end
  end

  task automatic fill_buffers();
    agg_beat_t f;
    agg_beat_t o;
    for (int a = 0; a < DEPTH; a++) begin
      f = random_word();
      o = random_word();
      feat_model[a] = f;
      out_model[a]  = o;
      @(posedge kernel_rst);
      fill_en   <= 1'b1;
      fill_addr <= agg_buf_addr_t'(a);
      fill_feat <= f;
      fill_out  <= o;
    end
    @(posedge kernel_rst);
    fill_en <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // build, predict, run and check one instruction
  //////////////////////////////////////////////////////////////////////
  task automatic run_instruction();
    logic [127:0]  inst;
    logic [63:0]   offset;
    logic [15:0]   apf;
    logic [15:0]   edges;
    logic [15:0]   in_start;
    logic [15:0]   out_start;
    logic [15:0]   adj;
    logic [14:0]   src;
    logic [14:0]   dst;
    logic          first;
    logic [31:0]   weight;
    logic [31:0]   lane;
    agg_buf_addr_t in_addr;
    agg_buf_addr_t out_addr;
    agg_beat_t     beat;
    agg_beat_t     sum;
    int            starts0;
    int            beats0;
    int            writes0;
    int            dones0;
    int            feat_reads0;
    int            out_reads0;
    int            wait_cycles;
    fill_buffers();
    apf       = 16'({$random(seed)} % 3 + 1);
    edges     = ({$random(seed)} % 2) ? 16'd16 : 16'd8;
    in_start  = 16'($random(seed));
    out_start = 16'($random(seed));
    adj       = 16'($random(seed));
    offset    = {$random(seed), $random(seed)};
    // unused fields carry noise
    inst = {edges, adj, 16'($random(seed)), out_start, apf, in_start, 32'($random(seed))};
    beat_q.delete();
    beat = '0;
    // few nodes so destinations repeat
    for (int e = 0; e < edges; e++) begin
      src    = 15'({$random(seed)} % 8);
      dst    = 15'({$random(seed)} % 4);
      first  = ({$random(seed)} % 4) == 0;
      weight = $random(seed);
      beat[(e % 8)*64 +: 64] = {weight, 1'b0, dst, first, src};
      if (e % 8 == 7) begin
        beat_q.push_back(beat);
      end
      for (int w = 0; w < apf; w++) begin
        in_addr  = agg_buf_addr_t'(in_start + apf * src + w);
        out_addr = agg_buf_addr_t'(out_start + apf * dst + w);
        for (int l = 0; l < `AGG_LANES; l++) begin
          lane = weight * feat_model[in_addr][l*LW +: LW];
          if (!first) begin
            lane = lane + out_model[out_addr][l*LW +: LW];
          end
          sum[l*LW +: LW] = lane;
        end
        out_model[out_addr] = sum;
        exp_addr_q.push_back(out_addr);
        exp_data_q.push_back(sum);
      end
    end
    starts0     = start_count;
    beats0      = beat_count;
    writes0     = write_count;
    dones0      = done_count;
    feat_reads0 = feat_read_count;
    out_reads0  = out_read_count;
    @(posedge kernel_rst);
    ap_start         <= 1'b1;
    ctrl_instruction <= inst;
    ctrl_addr_offset <= offset;
    @(posedge kernel_rst);
    ap_start <= 1'b0;
    @(negedge kernel_rst);
    check_value("dram_xfer_start_addr", offset + 64'(adj), dram_xfer_start_addr);
    check_value("dram_xfer_size_in_bytes", 32'(edges) * 32'd8, dram_xfer_size_in_bytes);
    foreach (beat_q[b]) begin
      repeat (1 + {$random(seed)} % 4) @(posedge kernel_rst);
      data_tvalid <= 1'b1;
      data_tdata  <= beat_q[b];
      wait_cycles = 0;
      do begin
        @(negedge kernel_rst);
        wait_cycles++;
        if (wait_cycles > 200) begin
          stop_run("timeout waiting for data_tready");
        end
      end while (!data_tready);
      @(posedge kernel_rst);
      data_tvalid <= 1'b0;
      data_tdata  <= random_word();
      @(negedge kernel_rst);
      check_value("data_tready", 1'b0, data_tready);
    end
    wait_cycles = 0;
    do begin
      @(negedge kernel_rst);
      wait_cycles++;
      if (wait_cycles > 1000) begin
        stop_run("timeout waiting for ap_done");
      end
    end while (!ap_done);
    check_value("write count", 32'(edges) * 32'(apf), write_count - writes0);
    check_value("feat_rd_en reads", 32'(edges) * 32'(apf), feat_read_count - feat_reads0);
    check_value("out_rd_en reads", 32'(edges) * 32'(apf), out_read_count - out_reads0);
    @(negedge kernel_rst);
    check_value("ap_done", 1'b0, ap_done);
    check_value("ap_done pulses", 1, done_count - dones0);
    check_value("read_start pulses", 1, start_count - starts0);
    check_value("accepted beats", 32'(edges) / 8, beat_count - beats0);
  endtask

  initial begin
    kernel_clk       = 1'b1;
    ap_start         = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_instruction = '0;
    data_tvalid      = 1'b0;
    data_tdata       = '0;
    fill_en          = 1'b0;
    fill_addr        = '0;
    fill_feat        = '0;
    fill_out         = '0;
    repeat (10) @(posedge kernel_rst);
    kernel_clk <= 1'b0;
    @(negedge kernel_rst);
    check_value("read_start", 1'b0, read_start);
    check_value("data_tready", 1'b0, data_tready);
    check_value("ap_done", 1'b0, ap_done);
    check_value("feat_rd_en", 1'b0, feat_rd_en);
    check_value("out_rd_en", 1'b0, out_rd_en);
    check_value("out_wr_en", 1'b0, out_wr_en);
    for (int n = 0; n < 4; n++) begin
      run_instruction();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/agg_pkg.sv
source/agg_controller.sv
source/agg_feature_fetch.sv
source/agg_mac_array.sv
source/agg_top.sv
verification/tb_agg_buffers.sv
verification/tb_agg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the aggregation engine testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary -f all.f --top-module tb_agg_top -Mdir build/obj_dir -o tb_agg_top

# the simulation exits non-zero on a failed check, the log decides
./build/obj_dir/tb_agg_top 2>&1 | tee build/sim.log || true

if grep -q "Everything OK" build/sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see build/sim.log"
  exit 1
fi
